// ==== design/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder (
    input  isa_pkg::instr_u            instr_i,
    output logic [4:0]                 rs1_o,
    output logic [4:0]                 rs2_o,
    output logic [4:0]                 rd_o,
    output ooo_pkg::unit_e             unit_o,
    output isa_pkg::alu_op_e           alu_op_o,
    output logic                       cmp_unsigned_o,
    output ooo_pkg::src_e              src1_sel_o,
    output ooo_pkg::src_e              src2_sel_o,
    output logic [isa_pkg::XLEN-1:0]   imm_o,
    output logic                       discard_o
);

    logic [2:0] funct3;
    logic       is_cmp;
    logic       is_sr;

    assign funct3 = instr_i.i_fmt.funct3;  // Same position in R and I forms
    assign is_cmp = (funct3 == isa_pkg::FUNCT3_SLT) || (funct3 == isa_pkg::FUNCT3_SLTU);
    assign is_sr  = (funct3 == isa_pkg::FUNCT3_SR);

    always_comb begin
        rs1_o          = instr_i.r_fmt.rs1;
        rs2_o          = instr_i.r_fmt.rs2;
        rd_o           = instr_i.r_fmt.rd;
        unit_o         = ooo_pkg::UNIT_NONE;
        alu_op_o       = isa_pkg::ALU_ADD;
        cmp_unsigned_o = 1'b0;
        src1_sel_o     = ooo_pkg::SRC_ZERO;
        src2_sel_o     = ooo_pkg::SRC_ZERO;
        imm_o          = '0;

        case (instr_i.r_fmt.opcode)
            isa_pkg::OPC_LUI: begin
                unit_o     = ooo_pkg::UNIT_ALU;
                src1_sel_o = ooo_pkg::SRC_ZERO;  // 0 + imm
                src2_sel_o = ooo_pkg::SRC_IMM;
                imm_o      = {instr_i.u_fmt.imm20, 12'h000};
            end

            isa_pkg::OPC_AUIPC: begin
                unit_o     = ooo_pkg::UNIT_ALU;
                src1_sel_o = ooo_pkg::SRC_PC;
                src2_sel_o = ooo_pkg::SRC_IMM;
                imm_o      = {instr_i.u_fmt.imm20, 12'h000};
            end

            isa_pkg::OPC_OP_IMM: begin
                src1_sel_o = ooo_pkg::SRC_REG;
                src2_sel_o = ooo_pkg::SRC_IMM;
                imm_o      = {{20{instr_i.i_fmt.imm12[11]}}, instr_i.i_fmt.imm12};
                if (is_cmp) begin
                    unit_o         = ooo_pkg::UNIT_CMP;
                    cmp_unsigned_o = (funct3 == isa_pkg::FUNCT3_SLTU);
                end else begin
                    // imm12[10] is instr[30], only meaningful for srai
                    unit_o   = ooo_pkg::UNIT_ALU;
                    alu_op_o = isa_pkg::alu_op_e'({is_sr & instr_i.i_fmt.imm12[10], funct3});
                end
            end

            isa_pkg::OPC_OP: begin
                src1_sel_o = ooo_pkg::SRC_REG;
                src2_sel_o = ooo_pkg::SRC_REG;
                if (is_cmp) begin
                    unit_o         = ooo_pkg::UNIT_CMP;
                    cmp_unsigned_o = (funct3 == isa_pkg::FUNCT3_SLTU);
                end else begin
                    unit_o   = ooo_pkg::UNIT_ALU;
                    alu_op_o = isa_pkg::alu_op_e'({instr_i.r_fmt.funct7[5]
                                                   & (is_sr || funct3 == 3'b000), funct3});
                end
            end

            default: ;  // Not handled here, dropped
        endcase
    end

    // Writes to x0 and unknown opcodes leave the queue without dispatch
    assign discard_o = (unit_o == ooo_pkg::UNIT_NONE) || (rd_o == 5'd0);

endmodule

// ==== design/isa_pkg.sv ====
package isa_pkg;

    parameter int XLEN = 32;

    // Major opcodes handled by this stage
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // funct3 codes that change routing
    parameter logic [2:0] FUNCT3_SLT  = 3'b010;
    parameter logic [2:0] FUNCT3_SLTU = 3'b011;
    parameter logic [2:0] FUNCT3_SR   = 3'b101;  // srl/sra and their immediate forms

    // Low three bits are funct3, top bit comes from instr[30]
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SLL = 4'b0001,
        ALU_XOR = 4'b0100,
        ALU_SRL = 4'b0101,
        ALU_OR  = 4'b0110,
        ALU_AND = 4'b0111,
        ALU_SUB = 4'b1000,
        ALU_SRA = 4'b1101
    } alu_op_e;

    // One instruction word, three views of the same bits
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } i_fmt;
        struct packed {
            logic [19:0] imm20;  // Upper immediate
            logic [4:0]  rd;
            opcode_e     opcode;
        } u_fmt;
    } instr_u;

endpackage

// ==== design/issue_control.sv ====
`timescale 1ns/100ps

module issue_control #(
    parameter int ROB_TAGS = ooo_pkg::DEFAULT_ROB_TAGS
) (
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           flush_i,
    input  logic                           iq_valid_i,
    input  logic [isa_pkg::XLEN-1:0]       iq_pc_i,
    output logic                           iq_pop_o,

    // Decoded instruction
    input  ooo_pkg::unit_e                 unit_i,
    input  isa_pkg::alu_op_e               alu_op_i,
    input  logic                           cmp_unsigned_i,
    input  ooo_pkg::src_e                  src1_sel_i,
    input  ooo_pkg::src_e                  src2_sel_i,
    input  logic [isa_pkg::XLEN-1:0]       imm_i,
    input  logic [4:0]                     rd_i,
    input  logic                           discard_i,

    // Resolved register operands
    input  logic [isa_pkg::XLEN-1:0]       value1_i,
    input  logic [$clog2(ROB_TAGS)-1:0]    tag1_i,
    input  logic [isa_pkg::XLEN-1:0]       value2_i,
    input  logic [$clog2(ROB_TAGS)-1:0]    tag2_i,

    input  logic                           rob_full_i,
    input  logic [$clog2(ROB_TAGS)-1:0]    rob_free_tag_i,
    input  logic                           alu_full_i,
    input  logic                           cmp_full_i,

    output logic                           rob_write_o,
    output logic [isa_pkg::XLEN-1:0]       rob_pc_o,
    output logic [4:0]                     rob_rd_o,
    output logic                           rename_we_o,
    output logic [4:0]                     rename_rd_o,
    output logic [$clog2(ROB_TAGS)-1:0]    rename_tag_o,
    output logic                           alu_valid_o,
    output isa_pkg::alu_op_e               alu_op_o,
    output logic                           cmp_valid_o,
    output logic                           cmp_unsigned_o,
    output logic [isa_pkg::XLEN-1:0]       src1_value_o,
    output logic [$clog2(ROB_TAGS)-1:0]    src1_tag_o,
    output logic                           src1_ready_o,
    output logic [isa_pkg::XLEN-1:0]       src2_value_o,
    output logic [$clog2(ROB_TAGS)-1:0]    src2_tag_o,
    output logic                           src2_ready_o,
    output logic [$clog2(ROB_TAGS)-1:0]    disp_tag_o
);

    localparam int TAG_W = $clog2(ROB_TAGS);

    logic                     live;
    logic                     station_full;
    logic                     can_dispatch;
    logic                     dispatch;
    logic [isa_pkg::XLEN-1:0] op1_value;
    logic [isa_pkg::XLEN-1:0] op2_value;
    logic [TAG_W-1:0]         op1_tag;
    logic [TAG_W-1:0]         op2_tag;

    function automatic logic [isa_pkg::XLEN-1:0] operand_value(
        input ooo_pkg::src_e             sel,
        input logic [isa_pkg::XLEN-1:0]  reg_value
    );
        case (sel)
            ooo_pkg::SRC_REG:  return reg_value;
            ooo_pkg::SRC_PC:   return iq_pc_i;
            ooo_pkg::SRC_ZERO: return '0;
            default:           return imm_i;
        endcase
    endfunction

    assign live         = iq_valid_i && !flush_i && !reset_i;
    assign station_full = (unit_i == ooo_pkg::UNIT_CMP) ? cmp_full_i : alu_full_i;
    assign can_dispatch = !rob_full_i && (rob_free_tag_i != '0) && !station_full;
    assign dispatch     = live && !discard_i && can_dispatch;

    // Same cycle as the dispatch decision, queue advances on this edge
    assign iq_pop_o = live && (discard_i || can_dispatch);

    assign op1_value = operand_value(src1_sel_i, value1_i);
    assign op2_value = operand_value(src2_sel_i, value2_i);
    assign op1_tag   = (src1_sel_i == ooo_pkg::SRC_REG) ? tag1_i : '0;  // Constants never wait
    assign op2_tag   = (src2_sel_i == ooo_pkg::SRC_REG) ? tag2_i : '0;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            alu_valid_o <= 1'b0;
            cmp_valid_o <= 1'b0;
            rob_write_o <= 1'b0;
            rename_we_o <= 1'b0;
        end else begin
            alu_valid_o <= dispatch && (unit_i == ooo_pkg::UNIT_ALU);
            cmp_valid_o <= dispatch && (unit_i == ooo_pkg::UNIT_CMP);
            rob_write_o <= dispatch;
            rename_we_o <= dispatch;
        end
    end

    // Payload only moves with a dispatch
    always_ff @(posedge clk) begin
        if (dispatch) begin
            alu_op_o       <= alu_op_i;
            cmp_unsigned_o <= cmp_unsigned_i;
            src1_value_o   <= op1_value;
            src1_tag_o     <= op1_tag;
            src1_ready_o   <= (op1_tag == '0);
            src2_value_o   <= op2_value;
            src2_tag_o     <= op2_tag;
            src2_ready_o   <= (op2_tag == '0);
            disp_tag_o     <= rob_free_tag_i;
            rob_pc_o       <= iq_pc_i;
            rob_rd_o       <= rd_i;
            rename_rd_o    <= rd_i;
            rename_tag_o   <= rob_free_tag_i;  // rd now waits on this entry
        end
    end

    a_one_station: assert property (@(posedge clk) disable iff (reset_i)
        !(alu_valid_o && cmp_valid_o))
        else $error("ALU and compare station dispatched together");

    a_rename_tag: assert property (@(posedge clk) disable iff (reset_i)
        rename_we_o |-> rename_tag_o != '0)
        else $error("Rename written with reserved tag 0");

    a_quiet_after_clear: assert property (@(posedge clk)
        (reset_i || flush_i) |=> !(alu_valid_o || cmp_valid_o || rob_write_o || rename_we_o))
        else $error("Dispatch output active after reset or flush");

endmodule

// ==== design/issue_stage.sv ====
`timescale 1ns/100ps

module issue_stage #(
    parameter int ROB_TAGS = ooo_pkg::DEFAULT_ROB_TAGS
) (
    input  logic                                    clk,
    input  logic                                    reset_i,
    input  logic                                    flush_i,

    input  logic                                    iq_valid_i,
    input  isa_pkg::instr_u                         iq_instr_i,
    input  logic [isa_pkg::XLEN-1:0]                iq_pc_i,
    output logic                                    iq_pop_o,

    output logic [4:0]                              rs1_o,
    output logic [4:0]                              rs2_o,
    input  logic [isa_pkg::XLEN-1:0]                rf_value1_i,
    input  logic [$clog2(ROB_TAGS)-1:0]             rf_tag1_i,
    input  logic [isa_pkg::XLEN-1:0]                rf_value2_i,
    input  logic [$clog2(ROB_TAGS)-1:0]             rf_tag2_i,

    input  logic                                    rob_full_i,
    input  logic [$clog2(ROB_TAGS)-1:0]             rob_free_tag_i,
    input  logic [ROB_TAGS-1:0]                     rob_ready_i,
    input  logic [ROB_TAGS-1:0][isa_pkg::XLEN-1:0]  rob_value_i,
    output logic                                    rob_write_o,
    output logic [isa_pkg::XLEN-1:0]                rob_pc_o,
    output logic [4:0]                              rob_rd_o,

    output logic                                    rename_we_o,
    output logic [4:0]                              rename_rd_o,
    output logic [$clog2(ROB_TAGS)-1:0]             rename_tag_o,

    input  logic                                    alu_full_i,
    input  logic                                    cmp_full_i,
    output logic                                    alu_valid_o,
    output isa_pkg::alu_op_e                        alu_op_o,
    output logic                                    cmp_valid_o,
    output logic                                    cmp_unsigned_o,
    output logic [isa_pkg::XLEN-1:0]                src1_value_o,
    output logic [$clog2(ROB_TAGS)-1:0]             src1_tag_o,
    output logic                                    src1_ready_o,
    output logic [isa_pkg::XLEN-1:0]                src2_value_o,
    output logic [$clog2(ROB_TAGS)-1:0]             src2_tag_o,
    output logic                                    src2_ready_o,
    output logic [$clog2(ROB_TAGS)-1:0]             disp_tag_o
);

    localparam int TAG_W = $clog2(ROB_TAGS);

    logic [4:0]               dec_rd;
    ooo_pkg::unit_e           dec_unit;
    isa_pkg::alu_op_e         dec_alu_op;
    logic                     dec_cmp_unsigned;
    ooo_pkg::src_e            dec_src1_sel;
    ooo_pkg::src_e            dec_src2_sel;
    logic [isa_pkg::XLEN-1:0] dec_imm;
    logic                     dec_discard;
    logic [isa_pkg::XLEN-1:0] res_value1;
    logic [isa_pkg::XLEN-1:0] res_value2;
    logic [TAG_W-1:0]         res_tag1;
    logic [TAG_W-1:0]         res_tag2;

    instr_decoder u_decoder (
        .instr_i        (iq_instr_i),
        .rs1_o          (rs1_o),
        .rs2_o          (rs2_o),
        .rd_o           (dec_rd),
        .unit_o         (dec_unit),
        .alu_op_o       (dec_alu_op),
        .cmp_unsigned_o (dec_cmp_unsigned),
        .src1_sel_o     (dec_src1_sel),
        .src2_sel_o     (dec_src2_sel),
        .imm_o          (dec_imm),
        .discard_o      (dec_discard)
    );

    operand_resolve #(.ROB_TAGS(ROB_TAGS)) u_resolve (
        .rf_value1_i (rf_value1_i),
        .rf_tag1_i   (rf_tag1_i),
        .rf_value2_i (rf_value2_i),
        .rf_tag2_i   (rf_tag2_i),
        .rob_ready_i (rob_ready_i),
        .rob_value_i (rob_value_i),
        .value1_o    (res_value1),
        .tag1_o      (res_tag1),
        .value2_o    (res_value2),
        .tag2_o      (res_tag2)
    );

    issue_control #(.ROB_TAGS(ROB_TAGS)) u_control (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush_i),
        .iq_valid_i     (iq_valid_i),
        .iq_pc_i        (iq_pc_i),
        .iq_pop_o       (iq_pop_o),
        .unit_i         (dec_unit),
        .alu_op_i       (dec_alu_op),
        .cmp_unsigned_i (dec_cmp_unsigned),
        .src1_sel_i     (dec_src1_sel),
        .src2_sel_i     (dec_src2_sel),
        .imm_i          (dec_imm),
        .rd_i           (dec_rd),
        .discard_i      (dec_discard),
        .value1_i       (res_value1),
        .tag1_i         (res_tag1),
        .value2_i       (res_value2),
        .tag2_i         (res_tag2),
        .rob_full_i     (rob_full_i),
        .rob_free_tag_i (rob_free_tag_i),
        .alu_full_i     (alu_full_i),
        .cmp_full_i     (cmp_full_i),
        .rob_write_o    (rob_write_o),
        .rob_pc_o       (rob_pc_o),
        .rob_rd_o       (rob_rd_o),
        .rename_we_o    (rename_we_o),
        .rename_rd_o    (rename_rd_o),
        .rename_tag_o   (rename_tag_o),
        .alu_valid_o    (alu_valid_o),
        .alu_op_o       (alu_op_o),
        .cmp_valid_o    (cmp_valid_o),
        .cmp_unsigned_o (cmp_unsigned_o),
        .src1_value_o   (src1_value_o),
        .src1_tag_o     (src1_tag_o),
        .src1_ready_o   (src1_ready_o),
        .src2_value_o   (src2_value_o),
        .src2_tag_o     (src2_tag_o),
        .src2_ready_o   (src2_ready_o),
        .disp_tag_o     (disp_tag_o)
    );

endmodule

// ==== design/ooo_pkg.sv ====
package ooo_pkg;

    // Reservation station that receives the instruction
    typedef enum logic [1:0] {
        UNIT_NONE = 2'd0,
        UNIT_ALU  = 2'd1,  // add, sub, shifts, logic
        UNIT_CMP  = 2'd2   // slt, sltu and immediate forms
    } unit_e;

    // Where a dispatched operand comes from
    typedef enum logic [1:0] {
        SRC_REG  = 2'd0,
        SRC_PC   = 2'd1,
        SRC_ZERO = 2'd2,
        SRC_IMM  = 2'd3
    } src_e;

    // Tag 0 is reserved for "no producer", so usable tags run 1..N-1
    parameter int DEFAULT_ROB_TAGS = 8;

endpackage

// ==== design/operand_resolve.sv ====
`timescale 1ns/100ps

module operand_resolve #(
    parameter int ROB_TAGS = ooo_pkg::DEFAULT_ROB_TAGS
) (
    input  logic [isa_pkg::XLEN-1:0]                rf_value1_i,
    input  logic [$clog2(ROB_TAGS)-1:0]             rf_tag1_i,
    input  logic [isa_pkg::XLEN-1:0]                rf_value2_i,
    input  logic [$clog2(ROB_TAGS)-1:0]             rf_tag2_i,
    input  logic [ROB_TAGS-1:0]                     rob_ready_i,
    input  logic [ROB_TAGS-1:0][isa_pkg::XLEN-1:0]  rob_value_i,
    output logic [isa_pkg::XLEN-1:0]                value1_o,
    output logic [$clog2(ROB_TAGS)-1:0]             tag1_o,
    output logic [isa_pkg::XLEN-1:0]                value2_o,
    output logic [$clog2(ROB_TAGS)-1:0]             tag2_o
);

    localparam int TAG_W = $clog2(ROB_TAGS);

    logic hit1;
    logic hit2;

    // Producer finished but not yet committed
    function automatic logic rob_hit(input logic [TAG_W-1:0] tag);
        return (tag != '0) && rob_ready_i[tag];
    endfunction

    assign hit1 = rob_hit(rf_tag1_i);
    assign hit2 = rob_hit(rf_tag2_i);

    assign value1_o = hit1 ? rob_value_i[rf_tag1_i] : rf_value1_i;
    assign tag1_o   = hit1 ? '0 : rf_tag1_i;
    assign value2_o = hit2 ? rob_value_i[rf_tag2_i] : rf_value2_i;
    assign tag2_o   = hit2 ? '0 : rf_tag2_i;

    // A ready ROB entry must never leave the operand waiting
    a_src1_bypass: assert final (!(rf_tag1_i != '0 && rob_ready_i[rf_tag1_i]) || tag1_o == '0)
        else $error("src1 left pending although ROB tag %0d is ready", rf_tag1_i);
    a_src2_bypass: assert final (!(rf_tag2_i != '0 && rob_ready_i[rf_tag2_i]) || tag2_o == '0)
        else $error("src2 left pending although ROB tag %0d is ready", rf_tag2_i);

endmodule

// ==== dv/issue_ref_model.svh ====
logic             exp_pop = 1'b0;
logic             exp_disp = 1'b0;
logic             exp_alu_valid = 1'b0;
logic             exp_cmp_valid = 1'b0;
logic [3:0]       exp_alu_op;
logic             exp_cmp_uns;
logic [31:0]      exp_src1_value;
logic [TAG_W-1:0] exp_src1_tag;
logic [31:0]      exp_src2_value;
logic [TAG_W-1:0] exp_src2_tag;
logic [TAG_W-1:0] exp_tag;
logic [31:0]      exp_pc;
logic [4:0]       exp_rd;

// Unit codes 0 none, 1 ALU, 2 compare
// Operand codes 0 register, 1 pc, 2 zero, 3 immediate
task automatic decode_expected(
    input  logic [31:0] word,
    output logic [1:0]  unit,
    output logic [3:0]  op,
    output logic        uns,
    output logic [1:0]  sel1,
    output logic [1:0]  sel2,
    output logic [31:0] imm
);
    logic [2:0] f3;
    logic       slt_form;
    f3       = word[14:12];
    slt_form = (f3 == 3'b010) || (f3 == 3'b011);
    unit     = 2'd0;
    op       = 4'h0;
    uns      = (f3 == 3'b011);
    sel1     = 2'd2;
    sel2     = 2'd2;
    imm      = '0;
    case (word[6:0])
        7'b0110111, 7'b0010111: begin
            unit = 2'd1;
            sel1 = word[5] ? 2'd2 : 2'd1;  // LUI adds to zero, AUIPC to pc
            sel2 = 2'd3;
            imm  = {word[31:12], 12'h000};
        end
        7'b0010011: begin
            unit = slt_form ? 2'd2 : 2'd1;
            op   = {(f3 == 3'b101) & word[30], f3};  // Only srai takes bit 30
            sel1 = 2'd0;
            sel2 = 2'd3;
            imm  = {{20{word[31]}}, word[31:20]};
        end
        7'b0110011: begin
            unit = slt_form ? 2'd2 : 2'd1;
            op   = {((f3 == 3'b101) || (f3 == 3'b000)) & word[30], f3};
            sel1 = 2'd0;
            sel2 = 2'd0;
        end
        default: ;
    endcase
endtask

task automatic operand_expected(
    input  logic [1:0]       sel,
    input  logic [31:0]      rf_value,
    input  logic [TAG_W-1:0] rf_tag,
    input  logic [31:0]      imm,
    output logic [31:0]      value,
    output logic [TAG_W-1:0] tag
);
    value = rf_value;
    tag   = rf_tag;
    if (rf_tag != 0 && rob_ready_i[rf_tag]) begin
        value = rob_value_i[rf_tag];  // Finished producer forwards its result
        tag   = '0;
    end
    if (sel != 2'd0) begin
        tag   = '0;
        value = (sel == 2'd1) ? iq_pc_i : (sel == 2'd3) ? imm : 32'h0;
    end
endtask

// Pop for this cycle, registered outputs for the next one
task automatic predict_cycle();
    logic [1:0]  unit;
    logic [1:0]  sel1;
    logic [1:0]  sel2;
    logic [31:0] imm;
    logic        live;
    logic        stall;
    logic        discard;
    decode_expected(instr_word, unit, exp_alu_op, exp_cmp_uns, sel1, sel2, imm);
    discard = (unit == 2'd0) || (instr_word[11:7] == 5'd0);
    live    = iq_valid_i && !flush_i && !reset_i;
    stall   = rob_full_i || (rob_free_tag_i == 0) || ((unit == 2'd2) ? cmp_full_i : alu_full_i);
    exp_pop       = live && (discard || !stall);
    exp_disp      = live && !discard && !stall;
    exp_alu_valid = exp_disp && (unit == 2'd1);
    exp_cmp_valid = exp_disp && (unit == 2'd2);
    operand_expected(sel1, rf_value1_i, rf_tag1_i, imm, exp_src1_value, exp_src1_tag);
    operand_expected(sel2, rf_value2_i, rf_tag2_i, imm, exp_src2_value, exp_src2_tag);
    exp_tag = rob_free_tag_i;
    exp_pc  = iq_pc_i;
    exp_rd  = instr_word[11:7];
endtask

task automatic check_dispatch();
    check_value("alu_valid_o", alu_valid_o, exp_alu_valid);
    check_value("cmp_valid_o", cmp_valid_o, exp_cmp_valid);
    check_value("rob_write_o", rob_write_o, exp_disp);
    check_value("rename_we_o", rename_we_o, exp_disp);
    if (exp_disp) begin
        check_value("src1_value_o", src1_value_o, exp_src1_value);
        check_value("src1_tag_o", src1_tag_o, exp_src1_tag);
        check_value("src1_ready_o", src1_ready_o, exp_src1_tag == 0);
        check_value("src2_value_o", src2_value_o, exp_src2_value);
        check_value("src2_tag_o", src2_tag_o, exp_src2_tag);
        check_value("src2_ready_o", src2_ready_o, exp_src2_tag == 0);
        check_value("disp_tag_o", disp_tag_o, exp_tag);
        check_value("rename_tag_o", rename_tag_o, exp_tag);
        check_value("rename_rd_o", rename_rd_o, exp_rd);
        check_value("rob_rd_o", rob_rd_o, exp_rd);
        check_value("rob_pc_o", rob_pc_o, exp_pc);
    end
    if (exp_alu_valid)
        check_value("alu_op_o", alu_op_o, exp_alu_op);
    if (exp_cmp_valid)
        check_value("cmp_unsigned_o", cmp_unsigned_o, exp_cmp_uns);
endtask

// ==== dv/tb_issue_stage.sv ====
`timescale 1ns/100ps

module tb_issue_stage;

    localparam int ROB_TAGS       = ooo_pkg::DEFAULT_ROB_TAGS;
    localparam int TAG_W          = $clog2(ROB_TAGS);
    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 100;

    logic                      clk = 1'b0;
    logic                      reset_i;
    logic                      flush_i;
    logic                      iq_valid_i;
    logic [31:0]               instr_word;
    logic [31:0]               iq_pc_i;
    logic                      iq_pop_o;
    logic [4:0]                rs1_o;
    logic [4:0]                rs2_o;
    logic [31:0]               rf_value1_i;
    logic [TAG_W-1:0]          rf_tag1_i;
    logic [31:0]               rf_value2_i;
    logic [TAG_W-1:0]          rf_tag2_i;
    logic                      rob_full_i;
    logic [TAG_W-1:0]          rob_free_tag_i;
    logic [ROB_TAGS-1:0]       rob_ready_i;
    logic [ROB_TAGS-1:0][31:0] rob_value_i;
    logic                      rob_write_o;
    logic [31:0]               rob_pc_o;
    logic [4:0]                rob_rd_o;
    logic                      rename_we_o;
    logic [4:0]                rename_rd_o;
    logic [TAG_W-1:0]          rename_tag_o;
    logic                      alu_full_i;
    logic                      cmp_full_i;
    logic                      alu_valid_o;
    isa_pkg::alu_op_e          alu_op_o;
    logic                      cmp_valid_o;
    logic                      cmp_unsigned_o;
    logic [31:0]               src1_value_o;
    logic [TAG_W-1:0]          src1_tag_o;
    logic                      src1_ready_o;
    logic [31:0]               src2_value_o;
    logic [TAG_W-1:0]          src2_tag_o;
    logic                      src2_ready_o;
    logic [TAG_W-1:0]          disp_tag_o;

    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   pops = 0;
    int   stalls = 0;
    logic take_next = 1'b0;  // Head left the queue last cycle

    issue_stage #(.ROB_TAGS(ROB_TAGS)) dut (
        .*,
        .iq_instr_i (instr_word)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s at %0t: got 0x%h, expected 0x%h", name, $time, actual, expected);
        end
    endtask

    `include "issue_ref_model.svh"

    // Four supported opcodes, loads and branches as unsupported ones
    function automatic logic [31:0] random_instr();
        logic [31:0] word;
        logic [6:0]  opcodes [10] = '{7'b0110111, 7'b0010111, 7'b0010011, 7'b0010011,
                                      7'b0010011, 7'b0110011, 7'b0110011, 7'b0110011,
                                      7'b0000011, 7'b1100011};
        word      = $urandom;
        word[6:0] = opcodes[$urandom % 10];
        if ($urandom % 12 == 0)
            word[11:7] = 5'd0;
        return word;
    endfunction

    task drive_inputs();
        int i;
        if (take_next) begin
            instr_word <= random_instr();
            iq_pc_i    <= iq_pc_i + 32'd4;
        end
        iq_valid_i     <= ($urandom % 10) != 0;
        flush_i        <= ($urandom % 50) == 0;
        rf_value1_i    <= $urandom;
        rf_value2_i    <= $urandom;
        rf_tag1_i      <= ($urandom % 2 == 0) ? '0 : TAG_W'($urandom);
        rf_tag2_i      <= ($urandom % 2 == 0) ? '0 : TAG_W'($urandom);
        rob_full_i     <= ($urandom % 10) == 0;
        rob_free_tag_i <= ($urandom % 10 == 0) ? '0 : TAG_W'(1 + $urandom % (ROB_TAGS - 1));
        rob_ready_i    <= ROB_TAGS'($urandom);
        alu_full_i     <= ($urandom % 6) == 0;
        cmp_full_i     <= ($urandom % 6) == 0;
        for (i = 0; i < ROB_TAGS; i++)
            rob_value_i[i] <= $urandom;
    endtask

    task automatic report_counts();
        $display("Closing: %0d checks, %0d errors, %0d instructions popped, %0d stall cycles",
                 checks, errors, pops, stalls);
    endtask

    initial begin
        forever #10 clk = ~clk;
    end

    // Last cycle's prediction is compared before this cycle's is made
    always @(negedge clk) begin
        check_dispatch();
        predict_cycle();
        check_value("iq_pop_o", iq_pop_o, exp_pop);
        check_value("rs1_o", rs1_o, instr_word[19:15]);
        check_value("rs2_o", rs2_o, instr_word[24:20]);
        take_next = iq_pop_o || flush_i;  // Flush empties the queue
        pops      = pops + iq_pop_o;
        stalls    = stalls + (iq_valid_i && !reset_i && !flush_i && !iq_pop_o);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            errors++;
            $display("Timeout: only %0d of %0d instructions issued within %0d cycles",
                     pops, NUM_INSTR, cycles);
            report_counts();
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h3319));
        reset_i        = 1'b1;
        flush_i        = 1'b0;
        iq_valid_i     = 1'b0;
        instr_word     = random_instr();
        iq_pc_i        = 32'h0000_1000;
        rf_value1_i    = '0;
        rf_tag1_i      = '0;
        rf_value2_i    = '0;
        rf_tag2_i      = '0;
        rob_full_i     = 1'b0;
        rob_free_tag_i = '0;
        rob_ready_i    = '0;
        rob_value_i    = '0;
        alu_full_i     = 1'b0;
        cmp_full_i     = 1'b0;
        repeat (8) begin
            @(posedge clk);
            drive_inputs();  // Pop must stay low under reset
        end
        reset_i <= 1'b0;
        while (pops < NUM_INSTR) begin
            @(posedge clk);
            drive_inputs();
        end
        repeat (2) @(posedge clk);
        report_counts();
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+dv
design/isa_pkg.sv
design/ooo_pkg.sv
design/instr_decoder.sv
design/operand_resolve.sv
design/issue_control.sv
design/issue_stage.sv
dv/tb_issue_stage.sv
